/* rtl/memoryTypes.sv */
package memoryTypes;

	// Operation the core presents to memory in the current cycle
	typedef enum logic [1:0]
	{
		nop = 2'b00, // Idle, no address decode needed
		load = 2'b01, // rs1 + immediateI
		storePreload = 2'b10, // Read half of read-modify-write, rs1 + immediateS
		store = 2'b11 // Write half, lands at end of cycle
	} MemoryMode;

	// funct3 of the load/store instruction
	typedef enum logic [2:0]
	{
		byteSigned = 3'b000, // lb / sb
		halfSigned = 3'b001, // lh / sh
		word = 3'b010, // lw / sw
		byteUnsigned = 3'b100, // lbu
		halfUnsigned = 3'b101 // lhu
	} AccessWidth;

	// Number of MMIO words in each direction
	localparam int MmioCount = 8;

	// First byte address of the MMIO window, top 32 bytes of memory
	localparam logic [31:0] MmioBase = 32'hFFFFFFE0;

	// Default RAM word address width, 1024 words = 4 KiB
	localparam int RamAddrWidth = 10;

	// Address map summary
	//   00000000..7FFFFFFF  RAM, aliased every 4 KiB by default
	//   80000000..FFFFFFDF  Reads zero, writes ignored
	//   FFFFFFE0..FFFFFFFC  MMIO, one word per index

	// Byte lanes are little-endian
	//   Offset 0 -> bits 7:0
	//   Offset 1 -> bits 15:8
	//   Offset 2 -> bits 23:16
	//   Offset 3 -> bits 31:24

	// Sub-word stores need storePreload then store
	// with identical operands on consecutive cycles;
	// a word store may skip the preload

	// Alignment rules
	//   Bytes never misaligned
	//   Halves misaligned at offsets 1 and 3
	//   Words misaligned unless offset 0

endpackage

/* rtl/DataAligner.sv */
module DataAligner
(
	input memoryTypes::AccessWidth accessWidth,
	input logic [1:0] offset, // Byte offset within the word
	input logic [31:0] rawWord, // Word as read from RAM or MMIO
	input logic [31:0] preloadWord, // Word captured by storePreload
	input logic [31:0] storeData, // rs2
	output logic [31:0] loadValue,
	output logic [31:0] storeWord
);
	import memoryTypes::*;

	logic [31:0] shifted; // Addressed lane moved down to bit 0
	logic [7:0] loadByte;
	logic [15:0] loadHalf;

	// Shift by 0, 8, 16 or 24 bits
	assign shifted = rawWord >> {offset, 3'b000};
	assign loadByte = shifted[7:0];
	assign loadHalf = shifted[15:0];

	// Load extraction and extension
	always_comb
	begin
		unique case (accessWidth)
			byteSigned:
			begin
				loadValue = {{24{loadByte[7]}}, loadByte}; // lb
			end
			byteUnsigned:
			begin
				loadValue = {24'h000000, loadByte}; // lbu
			end
			halfSigned:
			begin
				loadValue = {{16{loadHalf[15]}}, loadHalf}; // lh
			end
			halfUnsigned:
			begin
				loadValue = {16'h0000, loadHalf}; // lhu
			end
			word:
			begin
				loadValue = rawWord; // lw, offset must be 0
			end
			default:
			begin
				// Invalid funct3 returns zero
				loadValue = '0;
			end
		endcase
	end

	// Store merge into the preloaded word
	always_comb
	begin
		storeWord = preloadWord; // Untouched lanes keep old contents
		unique case (accessWidth)
			byteSigned, byteUnsigned:
			begin
				storeWord[{offset, 3'b000} +: 8] = storeData[7:0]; // sb
			end
			halfSigned, halfUnsigned:
			begin
				// Only offsets 0 and 2 are legal here
				storeWord[{offset[1], 4'b0000} +: 16] = storeData[15:0]; // sh
			end
			word:
			begin
				storeWord = storeData; // sw replaces everything
			end
			default:
			begin
				storeWord = preloadWord; // Write back unchanged
			end
		endcase
	end

endmodule

/* rtl/RamWrapper.sv */
module RamWrapper
#(
	parameter int ramAddrWidth = memoryTypes::RamAddrWidth
)
(
	input logic clock,

	// Instruction fetch port, read only
	input logic [ramAddrWidth-1:0] fetchIndex,
	output logic [31:0] fetchWord,

	// Data port
	input logic [ramAddrWidth-1:0] dataIndex,
	input logic writeEnable,
	input logic [31:0] writeWord,
	output logic [31:0] readWord
);
	localparam int Depth = 2 ** ramAddrWidth; // Words in the array

	logic [31:0] mem [Depth];

	// Array powers up cleared, reset never touches it
	initial
	begin
		for (int i = 0; i < Depth; i++)
		begin
			mem[i] = '0;
		end
	end

	// Data port, read-first on a same-index write
	always @(posedge clock)
	begin
		if (writeEnable)
		begin
			mem[dataIndex] <= writeWord;
		end
		readWord <= mem[dataIndex]; // Old word if written this edge
	end

	// Fetch port
	always_ff @(posedge clock)
	begin
		fetchWord <= mem[fetchIndex]; // One cycle after the address
	end

	// Fetch and data ports are independent;
	// a fetch of the index being written also sees the old word,
	// the new value shows on the following fetch

	// Depth is 2**ramAddrWidth words, so every index is in range
	// and higher address bits simply alias

endmodule

/* rtl/MemoryMappedIo.sv */
module MemoryMappedIo
(
	input logic clock,
	input logic rstN,

	// Access from the controller
	input logic [2:0] index, // Word within the MMIO window
	input logic writeEnable,
	input logic [31:0] writeWord,
	output logic [31:0] readWord,

	// External ports
	input logic [31:0] mmioInputs [memoryTypes::MmioCount],
	output logic [31:0] mmioOutputs [memoryTypes::MmioCount]
);
	import memoryTypes::*;

	// Output registers, one per index
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < MmioCount; i++)
			begin
				mmioOutputs[i] <= '0; // Outputs idle low
			end
		end
		else if (writeEnable)
		begin
			mmioOutputs[index] <= writeWord; // Only the addressed word changes
		end
	end

	// Reads return the input side, never the output registers.
	// The controller samples this at the end of the load cycle.
	assign readWord = mmioInputs[index];

	// Index 0 sits at FFFFFFE0, index 7 at FFFFFFFC
	// Both directions share one index, so a sub-word store
	// merges into the input word seen during its preload

endmodule

/* rtl/MemoryController.sv */
module MemoryController
#(
	parameter int ramAddrWidth = memoryTypes::RamAddrWidth
)
(
	input logic clock,
	input logic rstN,
	input memoryTypes::MemoryMode memoryMode,
	input memoryTypes::AccessWidth accessWidth,
	input logic [31:0] rs1,
	input logic [31:0] immediateI,
	input logic [31:0] immediateS,
	input logic [31:0] rs2, // Store data
	input logic [31:0] instructionAddress,
	input logic [31:0] mmioInputs [memoryTypes::MmioCount],
	output logic [31:0] memoryOutput,
	output logic [31:0] instruction,
	output logic memoryUnalignedAccess,
	output logic [31:0] mmioOutputs [memoryTypes::MmioCount]
);
	import memoryTypes::*;

	logic [31:0] address; // Effective byte address
	logic [1:0] offset;
	logic inMmio; // Inside FFFFFFE0..FFFFFFFC
	logic widthValid;
	logic storeEnable;
	logic ramWrite;
	logic mmioWrite;
	logic capture; // Load or preload samples the read word
	logic [31:0] ramReadWord;
	logic [31:0] mmioReadWord;
	logic [31:0] rawWord; // Word read by the previous load/preload
	logic [31:0] storeWord;
	logic [31:0] loadValue;

	logic loadPending; // Previous cycle was a load
	logic [31:0] heldOutput; // Last shown load value
	logic [31:0] mmioWordQ;
	logic isRamQ;
	logic isMmioQ;
	AccessWidth loadWidthQ;
	logic [1:0] loadOffsetQ;

	// Loads use the I immediate, both store phases the S immediate
	assign address = (memoryMode == load) ? rs1 + immediateI : rs1 + immediateS;
	assign offset = address[1:0];
	assign inMmio = address[31:5] == MmioBase[31:5];
	assign capture = (memoryMode == load) || (memoryMode == storePreload);

	// Misalignment, combinational in the same cycle
	always_comb
	begin
		widthValid = 1'b1;
		memoryUnalignedAccess = 1'b0;
		unique case (accessWidth)
			byteSigned, byteUnsigned: memoryUnalignedAccess = 1'b0; // Always fine
			halfSigned, halfUnsigned: memoryUnalignedAccess = offset[0]; // Offsets 1, 3
			word: memoryUnalignedAccess = offset != 2'b00;
			default: widthValid = 1'b0; // Bad funct3, flag stays low
		endcase
		if (memoryMode == nop)
		begin
			memoryUnalignedAccess = 1'b0;
		end
	end

	// Misaligned or invalid stores write nothing
	assign storeEnable = (memoryMode == store) && widthValid && !memoryUnalignedAccess;
	assign ramWrite = storeEnable && !address[31]; // Lower half
	assign mmioWrite = storeEnable && inMmio; // Rest of upper half ignored

	// Region and lane state for the word read this cycle
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			loadPending <= 1'b0;
			heldOutput <= '0;
			mmioWordQ <= '0;
			isRamQ <= 1'b0;
			isMmioQ <= 1'b0;
			loadWidthQ <= word;
			loadOffsetQ <= 2'b00;
		end
		else
		begin
			loadPending <= memoryMode == load;
			heldOutput <= memoryOutput; // Keeps value across non-load cycles
			if (capture)
			begin
				mmioWordQ <= mmioReadWord;
				isRamQ <= !address[31];
				isMmioQ <= inMmio;
			end
			if (memoryMode == load)
			begin
				loadWidthQ <= accessWidth;
				loadOffsetQ <= offset;
			end
		end
	end

	// Upper half outside the window reads zero
	assign rawWord = isMmioQ ? mmioWordQ : (isRamQ ? ramReadWord : '0);

	// New value right after the load edge, held until the next load
	assign memoryOutput = loadPending ? loadValue : heldOutput;

	// Load side uses the lane state of the previous load
	DataAligner loadAligner
	(
		.accessWidth(loadWidthQ),
		.offset(loadOffsetQ),
		.rawWord(rawWord),
		.preloadWord(rawWord),
		.storeData(rs2),
		.loadValue(loadValue),
		.storeWord()
	);

	// Store side merges into the word from the preload cycle
	DataAligner storeAligner
	(
		.accessWidth(accessWidth),
		.offset(offset),
		.rawWord(rawWord),
		.preloadWord(rawWord),
		.storeData(rs2),
		.loadValue(),
		.storeWord(storeWord)
	);

	RamWrapper #(.ramAddrWidth(ramAddrWidth)) ramWrapper
	(
		.clock(clock),
		.fetchIndex(instructionAddress[ramAddrWidth+1:2]), // Bits 1:0 ignored
		.fetchWord(instruction),
		.dataIndex(address[ramAddrWidth+1:2]),
		.writeEnable(ramWrite),
		.writeWord(storeWord),
		.readWord(ramReadWord)
	);

	MemoryMappedIo memoryMappedIo
	(
		.clock(clock),
		.rstN(rstN),
		.index(address[4:2]),
		.writeEnable(mmioWrite),
		.writeWord(storeWord),
		.readWord(mmioReadWord),
		.mmioInputs(mmioInputs),
		.mmioOutputs(mmioOutputs)
	);

endmodule

/* rtl/MemorySubsystem.sv */
module MemorySubsystem
(
	input logic clock,
	input logic rstN,

	// Data operation, held stable for the cycle
	input memoryTypes::MemoryMode memoryMode,
	input memoryTypes::AccessWidth accessWidth,
	input logic [31:0] rs1,
	input logic [31:0] immediateI,
	input logic [31:0] immediateS,
	input logic [31:0] rs2,
	output logic [31:0] memoryOutput, // Valid one cycle after the load
	output logic memoryUnalignedAccess, // Same cycle

	// Instruction fetch
	input logic [31:0] instructionAddress,
	output logic [31:0] instruction,

	// MMIO ports at FFFFFFE0..FFFFFFFC
	input logic [31:0] mmioInputs [memoryTypes::MmioCount],
	output logic [31:0] mmioOutputs [memoryTypes::MmioCount]
);
	import memoryTypes::*;

	// 4 KiB of RAM
	MemoryController #(.ramAddrWidth(RamAddrWidth)) memoryController
	(
		.clock(clock),
		.rstN(rstN),
		.memoryMode(memoryMode),
		.accessWidth(accessWidth),
		.rs1(rs1),
		.immediateI(immediateI),
		.immediateS(immediateS),
		.rs2(rs2),
		.instructionAddress(instructionAddress),
		.mmioInputs(mmioInputs),
		.memoryOutput(memoryOutput),
		.instruction(instruction),
		.memoryUnalignedAccess(memoryUnalignedAccess),
		.mmioOutputs(mmioOutputs)
	);

endmodule

/* testbench/MemorySubsystemTb.sv */
module MemorySubsystemTb;
	import memoryTypes::*;

	localparam int ClockPeriod = 40;
	localparam int FieldCount = 11; // Words per golden record
	localparam int MaxOps = 64;

	// Field positions inside one golden record
	localparam int FieldMode = 0;
	localparam int FieldWidth = 1;
	localparam int FieldRs1 = 2;
	localparam int FieldImmI = 3;
	localparam int FieldImmS = 4;
	localparam int FieldRs2 = 5;
	localparam int FieldFetch = 6;
	localparam int FieldInstr = 7;
	localparam int FieldLoad = 8;
	localparam int FieldFlag = 9;
	localparam int FieldMarker = 10; // Load value comes from an MMIO input

	logic clock;
	logic rstN;
	MemoryMode memoryMode;
	AccessWidth accessWidth;
	logic [31:0] rs1;
	logic [31:0] immediateI;
	logic [31:0] immediateS;
	logic [31:0] rs2;
	logic [31:0] instructionAddress;
	logic [31:0] mmioInputs [MmioCount];
	logic [31:0] memoryOutput;
	logic [31:0] instruction;
	logic memoryUnalignedAccess;
	logic [31:0] mmioOutputs [MmioCount];

	logic [31:0] golden [MaxOps * FieldCount];
	logic [31:0] inputCopy [MmioCount]; // Values driven on mmioInputs
	logic [31:0] expectedMmio [MmioCount]; // Model of the output registers
	logic [15:0] lfsrState;
	int opCount;
	bit loaded;

	MemorySubsystem uut
	(
		.clock(clock),
		.rstN(rstN),
		.memoryMode(memoryMode),
		.accessWidth(accessWidth),
		.rs1(rs1),
		.immediateI(immediateI),
		.immediateS(immediateS),
		.rs2(rs2),
		.memoryOutput(memoryOutput),
		.memoryUnalignedAccess(memoryUnalignedAccess),
		.instructionAddress(instructionAddress),
		.instruction(instruction),
		.mmioInputs(mmioInputs),
		.mmioOutputs(mmioOutputs)
	);

	initial
	begin
		clock = 1'b0;
		forever #(ClockPeriod / 2) clock = ~clock;
	end

	// Galois form, taps 16 14 13 11
	function automatic logic [15:0] stepLfsr(input logic [15:0] state);
		stepLfsr = (state >> 1) ^ (state[0] ? 16'hB400 : 16'h0000);
	endfunction

	// One LFSR step per bit, LSB first
	task automatic drawWord(output logic [31:0] value);
		for (int b = 0; b < 32; b++)
		begin
			value[b] = lfsrState[0];
			lfsrState = stepLfsr(lfsrState);
		end
	endtask

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic checkLoad(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			stopWithFailure($sformatf("** Error %s: expected %h, actual %h",
				testName, expected, actual));
		end
	endtask

	task automatic checkFlag(input string testName, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			stopWithFailure($sformatf("** Error %s: expected %b, actual %b",
				testName, expected, actual));
		end
	endtask

	task automatic checkInstruction(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			stopWithFailure($sformatf("** Error %s: expected %h, actual %h",
				testName, expected, actual));
		end
	endtask

	task automatic checkMmioOutput(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			stopWithFailure($sformatf("** Error %s: expected %h, actual %h",
				testName, expected, actual));
		end
	endtask

	task automatic driveOp(input int op);
		int base;
		base = op * FieldCount;
		memoryMode = MemoryMode'(golden[base + FieldMode][1:0]);
		accessWidth = AccessWidth'(golden[base + FieldWidth][2:0]);
		rs1 = golden[base + FieldRs1];
		immediateI = golden[base + FieldImmI];
		immediateS = golden[base + FieldImmS];
		rs2 = golden[base + FieldRs2];
		instructionAddress = golden[base + FieldFetch];
	endtask

	// Aligned word stores inside FFFFFFE0..FFFFFFFC land in the output registers
	task automatic updateMmioModel(input int op);
		int base;
		logic [31:0] address;
		base = op * FieldCount;
		address = golden[base + FieldRs1] + golden[base + FieldImmS];
		if (golden[base + FieldMode][1:0] == 2'd3 && golden[base + FieldWidth][2:0] == 3'd2
			&& address[1:0] == 2'b00 && address[31:5] == MmioBase[31:5])
		begin
			expectedMmio[address[4:2]] = golden[base + FieldRs2];
		end
	endtask

	// Results seen in the cycle after the operation
	task automatic checkResults(input int op);
		int base;
		logic [31:0] loadAddress;
		logic [31:0] expectedLoad;
		base = op * FieldCount;
		loadAddress = golden[base + FieldRs1] + golden[base + FieldImmI];
		expectedLoad = golden[base + FieldLoad];
		if (golden[base + FieldMarker][0])
		begin
			expectedLoad = inputCopy[loadAddress[4:2]]; // Word load from the window
		end
		checkLoad($sformatf("op %0d memoryOutput", op), expectedLoad, memoryOutput);
		checkInstruction($sformatf("op %0d instruction", op), golden[base + FieldInstr],
			instruction);
		for (int k = 0; k < MmioCount; k++)
		begin
			checkMmioOutput($sformatf("op %0d mmioOutputs[%0d]", op, k), expectedMmio[k],
				mmioOutputs[k]);
		end
	endtask

	initial
	begin
		logic [31:0] value;
		rstN = 1'b0;
		memoryMode = nop;
		accessWidth = word;
		rs1 = '0;
		immediateI = '0;
		immediateS = '0;
		rs2 = '0;
		instructionAddress = '0;
		lfsrState = 16'd37;
		for (int k = 0; k < MmioCount; k++)
		begin
			drawWord(value);
			mmioInputs[k] = value;
			inputCopy[k] = value;
			expectedMmio[k] = '0; // Outputs clear on reset
		end

		$readmemh("testbench/memoryGolden.txt", golden);
		opCount = 0;
		while (opCount < MaxOps && golden[opCount * FieldCount] !== 'x)
		begin
			opCount++; // Unfilled records stay X
		end
		if (opCount == 0)
		begin
			stopWithFailure("The golden file holds no operations");
		end
		loaded = 1'b1;

		repeat (4) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
		checkLoad("reset memoryOutput", 32'h0, memoryOutput);
		checkInstruction("reset instruction", 32'h0, instruction);
		for (int k = 0; k < MmioCount; k++)
		begin
			checkMmioOutput($sformatf("reset mmioOutputs[%0d]", k), 32'h0, mmioOutputs[k]);
		end

		for (int op = 0; op < opCount; op++)
		begin
			driveOp(op);
			@(posedge clock);
			// Flag is combinational, still valid at the closing edge
			checkFlag($sformatf("op %0d memoryUnalignedAccess", op),
				golden[op * FieldCount + FieldFlag][0], memoryUnalignedAccess);
			updateMmioModel(op);
			@(negedge clock);
			checkResults(op);
		end

		$display("TESTS PASSED");
		$finish;
	end

	// Run length bound from the number of golden records
	initial
	begin
		wait (loaded);
		#((opCount + 10) * ClockPeriod);
		stopWithFailure("Watchdog expired before the operations finished");
	end

endmodule

/* testbench/memoryGolden.txt */
// mode width rs1 immI immS rs2 fetchAddr expInstr expLoad expFlag mmioMarker
// mode 0 nop 1 load 2 storePreload 3 store, width is funct3, marker 1 takes load from mmioInputs
// Word store and reload
3 2 00000100 0 0 deadbeef 0 0 0 0 0
1 2 00000100 0 0 0 100 deadbeef deadbeef 0 0
3 2 000000f0 7fc 14 12345678 0 0 deadbeef 0 0
1 2 00000100 4 ff0 0 104 12345678 12345678 0 0
// Byte store at 102 then byte loads
2 0 00000100 0 2 ffffffa5 100 deadbeef 12345678 0 0
3 0 00000100 0 2 ffffffa5 100 deadbeef 12345678 0 0
1 0 00000100 2 0 0 100 dea5beef ffffffa5 0 0
1 4 00000100 2 0 0 0 0 000000a5 0 0
1 0 00000103 0 0 0 104 12345678 ffffffde 0 0
1 4 00000101 0 0 0 0 0 000000be 0 0
1 0 00000104 0 0 0 0 0 00000078 0 0
// Half stores and half loads
2 1 00000104 0 2 abcd8001 100 dea5beef 00000078 0 0
3 1 00000104 0 2 abcd8001 104 12345678 00000078 0 0
1 1 00000104 2 0 0 104 80015678 ffff8001 0 0
1 5 00000104 2 0 0 0 0 00008001 0 0
1 1 00000104 0 0 0 0 0 00005678 0 0
1 2 00000104 0 0 0 0 0 80015678 0 0
2 1 00000000 0 100 7f7f 0 0 80015678 0 0
3 1 00000000 0 100 7f7f 0 0 80015678 0 0
1 2 00000000 100 0 0 100 dea57f7f dea57f7f 0 0
// Misaligned stores, nop and invalid width
3 2 00000101 0 0 11111111 0 0 dea57f7f 1 0
3 2 00000100 0 2 22222222 0 0 dea57f7f 1 0
2 1 00000100 0 3 3333 0 0 dea57f7f 1 0
3 1 00000100 0 3 3333 0 0 dea57f7f 1 0
3 1 00000104 0 1 4444 0 0 dea57f7f 1 0
0 2 00000101 0 0 0 0 0 dea57f7f 0 0
2 3 00000101 0 0 0 0 0 dea57f7f 0 0
1 2 00000100 0 0 0 100 dea57f7f dea57f7f 0 0
1 2 00000104 0 0 0 104 80015678 80015678 0 0
// Byte at offset 3 is never misaligned
2 0 00000104 0 3 c3 0 0 80015678 0 0
3 0 00000104 0 3 c3 0 0 80015678 0 0
1 0 00000104 3 0 0 104 c3015678 ffffffc3 0 0
// MMIO window and the rest of the upper half
3 2 ffffff00 0 e0 cafef00d 107 c3015678 ffffffc3 0 0
3 2 ffffff00 0 fc 0badc0de 0 0 ffffffc3 0 0
3 2 80000000 0 0 55555555 0 0 ffffffc3 0 0
3 2 ffffffd0 0 c 77777777 0 0 ffffffc3 0 0
1 2 ffffffe0 0 0 0 0 0 0 0 1
1 2 ffffff00 f4 0 0 0 0 0 0 1
1 2 fffffffc 0 0 0 0 0 0 0 1
1 2 ffffffdc 0 0 0 0 0 0 0 0
1 2 80000000 0 0 0 0 0 0 0 0
1 2 00000000 0 0 0 0 0 0 0 0

/* src.f */
rtl/memoryTypes.sv
rtl/DataAligner.sv
rtl/RamWrapper.sv
rtl/MemoryMappedIo.sv
rtl/MemoryController.sv
rtl/MemorySubsystem.sv
testbench/MemorySubsystemTb.sv

/* Bender.yml */
package:
  name: memory_subsystem

sources:
  - rtl/memoryTypes.sv
  - rtl/DataAligner.sv
  - rtl/RamWrapper.sv
  - rtl/MemoryMappedIo.sv
  - rtl/MemoryController.sv
  - rtl/MemorySubsystem.sv
  - target: test
    files:
      - testbench/MemorySubsystemTb.sv
